// ==== Bender.yml ====
package:
  name: obi_mem

sources:
  # RTL in compile order
  - files:
      - logic/obi_mem_pkg.sv
      - logic/obi_protocol_monitor.sv
      - logic/obi_grant_ctrl.sv
      - logic/sram_bank.sv
      - logic/obi_response_fifo.sv
      - logic/obi_mem_top.sv

  # Testbench, top module obi_mem_tb
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/obi_mem_tb.sv

// ==== logic/obi_grant_ctrl.sv ====
/*
 * OBI grant controller
 * Inserts a fixed number of wait states and grants only with response space
 */

`timescale 1ns/10ps

module obi_grant_ctrl #(
  parameter int WAIT_CYCLES = 1
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       req,
  input  logic       payload_changed,
  input  logic [2:0] fifo_free,
  output logic       gnt
);

  // Counter wide enough to hold WAIT_CYCLES, at least one bit
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_CYCLES);

  logic [CNT_W-1:0] wait_cnt;
  logic             wait_done;
  logic             has_space;

  // ------------------------------------------------
  // Wait state counter
  // ------------------------------------------------

  // Counts cycles for which req has been held with an unchanged payload
  assign wait_done = (wait_cnt == WAIT_LAST);

  // At least one free slot not already promised to an earlier grant
  assign has_space = (fifo_free != 3'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (!req || payload_changed || gnt) begin
      // Dropped req, changed payload or a finished transfer start a new wait
      wait_cnt <= '0;
    end else if (!wait_done) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // ------------------------------------------------
  // Grant decision
  // ------------------------------------------------

  // A payload change this cycle cancels the grant and restarts the wait,
  // so the transfer always carries a payload that was held for the full count
  assign gnt = req & ~payload_changed & wait_done & has_space;

endmodule

// ==== logic/obi_mem_pkg.sv ====
/*
 * OBI memory subsystem shared definitions
 * Bus widths plus the request, response and monitor status records
 */

package obi_mem_pkg;

  // ------------------------------------------------
  // Bus widths
  // ------------------------------------------------

  // Only the 32-bit OBI data port is supported
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int BE_WIDTH   = DATA_WIDTH / 8;

  // ------------------------------------------------
  // Address phase payload
  // ------------------------------------------------

  // Everything that must stay stable from req until gnt
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  we;
    logic [BE_WIDTH-1:0]   be;
    logic [DATA_WIDTH-1:0] wdata;
  } obi_req_t;

  // ------------------------------------------------
  // Response phase payload
  // ------------------------------------------------

  // Read data is zero for writes and for rejected requests
  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
  } obi_rsp_t;

  // ------------------------------------------------
  // Protocol monitor status
  // ------------------------------------------------

  // Sticky rule flags and a saturating count of failing cycles
  typedef struct packed {
    logic        addr_unstable;
    logic        req_dropped;
    logic        be_zero;
    logic        be_noncontig;
    logic        be_misaligned;
    logic [15:0] violation_count;
  } mon_status_t;

endpackage

// ==== logic/obi_mem_top.sv ====
/*
 * OBI memory subsystem top level
 * Joins the protocol monitor, grant controller, SRAM bank and response FIFO
 */

`timescale 1ns/10ps

module obi_mem_top #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_CYCLES = 1,
  parameter int FIFO_DEPTH  = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  obi_mem_pkg::obi_req_t    req_payload,
  input  logic                     rready,
  input  logic                     status_clear,
  output logic                     gnt,
  output logic                     rvalid,
  output obi_mem_pkg::obi_rsp_t    rsp_payload,
  output obi_mem_pkg::mon_status_t status
);

  import obi_mem_pkg::*;

  logic        req_illegal;
  logic        payload_changed;
  logic [2:0]  fifo_free;
  logic        write_en;
  logic [31:0] sram_rdata;
  logic        push_q;
  logic        err_q;
  logic        zero_data_q;
  obi_rsp_t    push_rsp;

  // ------------------------------------------------
  // Address phase
  // ------------------------------------------------

  obi_protocol_monitor #(
    .MEM_WORDS (MEM_WORDS)
  ) monitor_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .req_payload     (req_payload),
    .gnt             (gnt),
    .status_clear    (status_clear),
    .req_illegal     (req_illegal),
    .payload_changed (payload_changed),
    .status          (status)
  );

  obi_grant_ctrl #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) grant_ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .payload_changed (payload_changed),
    .fifo_free       (fifo_free),
    .gnt             (gnt)
  );

  // Only a legal granted write may touch the memory
  assign write_en = req & gnt & req_payload.we & ~req_illegal;

  sram_bank #(
    .MEM_WORDS (MEM_WORDS)
  ) sram_i (
    .clk       (clk),
    .write_en  (write_en),
    .word_addr (req_payload.addr[9:2]),
    .be        (req_payload.be),
    .wdata     (req_payload.wdata),
    .rdata     (sram_rdata)
  );

  // ------------------------------------------------
  // Response phase
  // ------------------------------------------------

  // The push follows the grant by one cycle, when the read data is out
  always_ff @(posedge clk) begin
    if (reset) begin
      push_q <= 1'b0;
    end else begin
      push_q <= gnt;
    end
  end

  // Response kind captured with the grant
  always_ff @(posedge clk) begin
    err_q       <= req_illegal;
    zero_data_q <= req_payload.we | req_illegal;
  end

  // Writes and refused requests answer with zero data
  assign push_rsp.rdata = zero_data_q ? '0 : sram_rdata;
  assign push_rsp.err   = err_q;

  obi_response_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) rsp_fifo_i (
    .clk           (clk),
    .reset         (reset),
    .push          (push_q),
    .push_rsp      (push_rsp),
    .rready        (rready),
    .grant_pending (gnt),
    .rvalid        (rvalid),
    .rsp_payload   (rsp_payload),
    .fifo_free     (fifo_free)
  );

endmodule

// ==== logic/obi_protocol_monitor.sv ====
/*
 * OBI protocol monitor
 * Checks the address phase rules, keeps sticky flags and a violation count,
 * and marks requests that must be answered with an error
 */

`timescale 1ns/10ps

module obi_protocol_monitor #(
  parameter int MEM_WORDS = 256
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  obi_mem_pkg::obi_req_t    req_payload,
  input  logic                     gnt,
  input  logic                     status_clear,
  output logic                     req_illegal,
  output logic                     payload_changed,
  output obi_mem_pkg::mon_status_t status
);

  import obi_mem_pkg::*;

  // Returns one for the ten byte enable patterns with a single run of ones
  function automatic logic be_is_contiguous(input logic [BE_WIDTH-1:0] be);
    logic ok;
    case (be)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: ok = 1'b1;
      4'b0011, 4'b0110, 4'b1100:          ok = 1'b1;
      4'b0111, 4'b1110:                   ok = 1'b1;
      4'b1111:                            ok = 1'b1;
      default:                            ok = 1'b0;
    endcase
    return ok;
  endfunction

  // Byte offset implied by the lowest set enable
  function automatic logic [1:0] lowest_be_offset(input logic [BE_WIDTH-1:0] be);
    logic [1:0] offset;
    casez (be)
      4'b???1: offset = 2'd0;
      4'b??10: offset = 2'd1;
      4'b?100: offset = 2'd2;
      4'b1000: offset = 2'd3;
      default: offset = 2'd0;
    endcase
    return offset;
  endfunction

  // Byte size of the memory, used for the range check
  localparam logic [ADDR_WIDTH-1:0] MEM_BYTES = ADDR_WIDTH'(MEM_WORDS * 4);

  // ------------------------------------------------
  // Previous cycle of the address phase
  // ------------------------------------------------

  logic        prev_req;
  logic        prev_gnt;
  obi_req_t    prev_payload;
  logic        waiting;
  logic        req_dropped_now;
  logic        be_zero_now;
  logic        be_noncontig_now;
  logic        be_misaligned_now;
  logic        out_of_range;
  logic        any_fail;
  mon_status_t status_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_req <= 1'b0;
      prev_gnt <= 1'b0;
    end else begin
      prev_req <= req;
      prev_gnt <= gnt;
    end
  end

  // The payload copy only matters while prev_req is set
  always_ff @(posedge clk) begin
    prev_payload <= req_payload;
  end

  // A request was open last cycle and was not granted
  assign waiting = prev_req & ~prev_gnt;

  // Stability rules, checked against the registered copy
  assign payload_changed = waiting & req & (req_payload != prev_payload);
  assign req_dropped_now = waiting & ~req;

  // ------------------------------------------------
  // Byte enable decode
  // ------------------------------------------------

  assign be_zero_now      = req & (req_payload.be == '0);
  assign be_noncontig_now = req & (req_payload.be != '0) & ~be_is_contiguous(req_payload.be);

  // Misalignment is judged from the lowest enable, as for any nonzero be
  assign be_misaligned_now = req & (req_payload.be != '0) &
                             (req_payload.addr[1:0] != lowest_be_offset(req_payload.be));

  assign out_of_range = req_payload.addr >= MEM_BYTES;

  // Any request the memory must refuse, looked at by the write strobe and the response
  assign req_illegal = (req_payload.be == '0) | ~be_is_contiguous(req_payload.be) |
                       (req_payload.addr[1:0] != lowest_be_offset(req_payload.be)) |
                       out_of_range;

  assign any_fail = payload_changed | req_dropped_now | be_zero_now |
                    be_noncontig_now | be_misaligned_now;

  // ------------------------------------------------
  // Sticky status
  // ------------------------------------------------

  // Flags land one cycle after the breach, a clear request wins over a new breach
  always_ff @(posedge clk) begin
    if (reset || status_clear) begin
      status_q <= '0;
    end else begin
      status_q.addr_unstable <= status_q.addr_unstable | payload_changed;
      status_q.req_dropped   <= status_q.req_dropped | req_dropped_now;
      status_q.be_zero       <= status_q.be_zero | be_zero_now;
      status_q.be_noncontig  <= status_q.be_noncontig | be_noncontig_now;
      status_q.be_misaligned <= status_q.be_misaligned | be_misaligned_now;
      // Count failing cycles and hold at the top value
      if (any_fail && (status_q.violation_count != '1)) begin
        status_q.violation_count <= status_q.violation_count + 16'd1;
      end
    end
  end

  assign status = status_q;

endmodule

// ==== logic/obi_response_fifo.sv ====
/*
 * OBI response FIFO
 * In-order response queue with rvalid/rready output and a free slot count
 */

`timescale 1ns/10ps

module obi_response_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  obi_mem_pkg::obi_rsp_t push_rsp,
  input  logic                  rready,
  input  logic                  grant_pending,
  output logic                  rvalid,
  output obi_mem_pkg::obi_rsp_t rsp_payload,
  output logic [2:0]            fifo_free
);

  import obi_mem_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

  obi_rsp_t         entries [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             in_flight;
  logic             pop;

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------

  // A response leaves when the requester accepts it
  assign pop = rvalid & rready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_flight <= 1'b0;
    end else begin
      // Last cycle's grant turns into a push this cycle
      in_flight <= grant_pending;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= push_rsp;
    end
  end

  // Head entry is shown until it is taken
  assign rvalid      = (count != '0);
  assign rsp_payload = entries[rd_ptr];

  // ------------------------------------------------
  // Space report
  // ------------------------------------------------

  // The slot promised to the grant still on its way is already spoken for
  // A pop in this cycle is not credited, which keeps gnt independent of rready
  assign fifo_free = 3'(CNT_FULL - count - CNT_W'(in_flight));

endmodule

// ==== logic/sram_bank.sv ====
/*
 * Word wide SRAM bank
 * Byte enable masked writes and a registered read of the addressed word
 */

`timescale 1ns/10ps

module sram_bank #(
  parameter int MEM_WORDS = 256
) (
  input  logic        clk,
  input  logic        write_en,
  input  logic [7:0]  word_addr,
  input  logic [3:0]  be,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  // Contents are undefined after power up, as in a real macro
  logic [31:0] mem [MEM_WORDS];

  // ------------------------------------------------
  // Write port
  // ------------------------------------------------

  // Each enabled byte lane overwrites its own eight bits
  always_ff @(posedge clk) begin
    if (write_en) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (be[lane]) begin
          mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
        end
      end
    end
  end

  // ------------------------------------------------
  // Read port
  // ------------------------------------------------

  // Read data is ready one cycle after the address is presented
  // A write to the same word returns the old contents
  always_ff @(posedge clk) begin
    rdata <= mem[word_addr];
  end

endmodule

// ==== tb.f ====
logic/obi_mem_pkg.sv
logic/obi_protocol_monitor.sv
logic/obi_grant_ctrl.sv
logic/sram_bank.sv
logic/obi_response_fifo.sv
logic/obi_mem_top.sv
test/tb_clock_gen.sv
test/obi_mem_tb.sv

// ==== test/obi_mem_tb.sv ====
/*
 * OBI memory subsystem testbench
 * LFSR driven requests checked against a memory, response queue and protocol model
 */

`timescale 1ns/10ps

module obi_mem_tb;

  import obi_mem_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int WAIT_CYCLES = 1;
  localparam int FIFO_DEPTH  = 4;
  localparam int N_RUN       = 48;
  localparam int N_BREACH    = 16;
  // Preload, four tests of 2 * N_RUN requests each, then up to two per breach
  localparam int TOTAL_REQ   = MEM_WORDS + 8 * N_RUN + 2 * N_BREACH;
  localparam int WATCHDOG_CYCLES = TOTAL_REQ * (WAIT_CYCLES + 20);

  logic        clk;
  logic        reset;
  logic        req;
  obi_req_t    req_payload;
  logic        rready;
  logic        status_clear;
  logic        gnt;
  logic        rvalid;
  obi_rsp_t    rsp_payload;
  mon_status_t status;

  // Separate streams keep rready independent of the request sequence
  logic [31:0] stim_lfsr  = 32'h689419c1;
  logic [31:0] ready_lfsr = 32'h689419c1;
  logic        ready_random = 1'b0;

  logic [31:0] model_mem [MEM_WORDS];
  obi_rsp_t    exp_q [$];
  int          check_words [$];
  mon_status_t model_status;
  logic        last_req;
  logic        last_gnt;
  obi_req_t    last_payload;
  int          held_cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_checks = 0;
  int          test_errors = 0;

  tb_clock_gen clock_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  obi_mem_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) obi_mem_top_i (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .req_payload  (req_payload),
    .rready       (rready),
    .status_clear (status_clear),
    .gnt          (gnt),
    .rvalid       (rvalid),
    .rsp_payload  (rsp_payload),
    .status       (status)
  );

  // --------------------------------------------------
  // Random numbers
  // --------------------------------------------------

  // Right shifting Galois step with feedback mask 32'h80200003
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One step per bit taken, the first bit lands in the LSB
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = stim_lfsr[0];
      stim_lfsr = lfsr_next(stim_lfsr);
    end
    return v;
  endfunction

  // rready is high one cycle in four on average
  function automatic logic ready_draw();
    logic [1:0] v;
    for (int i = 0; i < 2; i++) begin
      v[i] = ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
    end
    return v == 2'b00;
  endfunction

  // --------------------------------------------------
  // Bus rules
  // --------------------------------------------------

  // Shift out trailing zeros, what is left must be a run of ones
  function automatic logic be_contiguous(input logic [3:0] be);
    logic [3:0] v;
    v = be;
    if (v == 4'b0000) return 1'b0;
    while (!v[0]) v = v >> 1;
    return ((v & (v + 1)) == 0);
  endfunction

  function automatic int lowest_lane(input logic [3:0] be);
    for (int i = 0; i < 4; i++) begin
      if (be[i]) return i;
    end
    return 0;
  endfunction

  function automatic logic is_illegal(input obi_req_t p);
    return !be_contiguous(p.be) || (p.addr[1:0] != lowest_lane(p.be)) ||
           (p.addr >= MEM_WORDS * 4);
  endfunction

  // Legal access of one to four bytes, a full word when full is set
  function automatic obi_req_t legal_req(input logic we, input logic full);
    obi_req_t p;
    int start;
    int len;
    start   = full ? 0 : int'(take_bits(2));
    len     = full ? 4 : int'(take_bits(2) % (4 - start)) + 1;
    p.addr  = (take_bits(16) % MEM_WORDS) * 4 + start;
    p.we    = we;
    p.be    = 4'(((1 << len) - 1) << start);
    p.wdata = take_bits(32);
    return p;
  endfunction

  // Kind 0 zero be, 1 gapped be, 2 wrong offset, 3 beyond the memory
  function automatic obi_req_t illegal_req(input int kind);
    obi_req_t p;
    p = legal_req(take_bits(1), 1'b0);
    case (kind)
      0: p.be = 4'b0000;
      1: p.be = take_bits(1) ? 4'b0101 : 4'b1011;
      2: p.addr[1:0] = 2'(lowest_lane(p.be) + 1 + take_bits(1));
      default: p.addr = p.addr + MEM_WORDS * 4 * (1 + take_bits(4));
    endcase
    return p;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------

  task automatic check_rsp(input obi_rsp_t got, input obi_rsp_t exp, input string what);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED at time %0t: %s rdata %h err %b, expected rdata %h err %b",
               $time, what, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_status(input mon_status_t got, input mon_status_t exp,
                              input string what);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED at time %0t: %s flags %b count %0d, expected flags %b count %0d",
               $time, what, got[20:16], got.violation_count, exp[20:16],
               exp.violation_count);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Reference model, sampled mid-cycle
  // --------------------------------------------------

  always @(negedge clk) begin : model_cycle
    obi_rsp_t    exp;
    logic        waiting;
    logic        changed;
    logic [4:0]  flags;
    logic [31:0] mask;
    int          word;
    if (reset) begin
      model_status = '0;
      last_req = 1'b0;
      last_gnt = 1'b0;
      held_cycles = 0;
    end else begin
      waiting = last_req && !last_gnt;
      changed = waiting && req && (req_payload != last_payload);
      // Breaches in this cycle, ordered like the flag fields of the status
      flags = {changed,
               waiting && !req,
               req && (req_payload.be == 4'b0000),
               req && (req_payload.be != 4'b0000) && !be_contiguous(req_payload.be),
               req && (req_payload.be != 4'b0000) &&
               (req_payload.addr[1:0] != lowest_lane(req_payload.be))};
      if (status_clear) begin
        model_status = '0;
      end else begin
        model_status[20:16] = model_status[20:16] | flags;
        if ((flags != 5'b0) && (model_status.violation_count != 16'hffff)) begin
          model_status.violation_count++;
        end
      end
      // A grant needs req held unchanged for the full wait count
      if (gnt) begin
        check_bit(req && !changed && (held_cycles >= WAIT_CYCLES), 1'b1, "gnt timing");
      end
      if (!req || changed || gnt) begin
        held_cycles = 0;
      end else begin
        held_cycles++;
      end
      // A transfer books its response now and updates the memory model
      if (req && gnt) begin
        word      = int'(req_payload.addr >> 2);
        exp.err   = is_illegal(req_payload);
        exp.rdata = '0;
        if (!req_payload.we && !exp.err) begin
          exp.rdata = model_mem[word];
        end
        exp_q.push_back(exp);
        if (req_payload.we && !exp.err) begin
          mask = {{8{req_payload.be[3]}}, {8{req_payload.be[2]}},
                  {8{req_payload.be[1]}}, {8{req_payload.be[0]}}};
          model_mem[word] = (model_mem[word] & ~mask) | (req_payload.wdata & mask);
        end
      end
      if (rvalid && rready) begin
        if (exp_q.size() == 0) begin
          errors++;
          test_errors++;
          $display("Response at time %0t arrived with no request outstanding", $time);
        end else begin
          check_rsp(rsp_payload, exp_q.pop_front(), "response");
        end
      end
      last_req = req;
      last_gnt = gnt;
    end
    last_payload = req_payload;
  end

  always @(posedge clk) begin
    rready <= ready_random ? ready_draw() : 1'b1;
  end

  // --------------------------------------------------
  // Bus driving
  // --------------------------------------------------

  // Present a request and return in the middle of its grant cycle
  task automatic send_request(input obi_req_t p);
    @(posedge clk);
    req         <= 1'b1;
    req_payload <= p;
    @(negedge clk);
    while (!gnt) @(negedge clk);
  endtask

  task automatic release_req();
    int gap;
    gap = take_bits(2);
    @(posedge clk);
    req <= 1'b0;
    repeat (gap) @(posedge clk);
  endtask

  // The second payload replaces the first one cycle before any grant
  task automatic send_with_change(input obi_req_t p, input obi_req_t alt);
    @(posedge clk);
    req         <= 1'b1;
    req_payload <= p;
    @(negedge clk);
    if (!gnt) begin
      send_request(alt);
    end
  endtask

  // req falls for one cycle while the request is still waiting
  task automatic send_with_drop(input obi_req_t p);
    @(posedge clk);
    req         <= 1'b1;
    req_payload <= p;
    @(negedge clk);
    if (!gnt) begin
      @(posedge clk);
      req <= 1'b0;
      send_request(p);
    end
  endtask

  task automatic read_back();
    obi_req_t p;
    while (check_words.size() != 0) begin
      p.addr  = check_words.pop_front() * 4;
      p.we    = 1'b0;
      p.be    = 4'b1111;
      p.wdata = take_bits(32);
      send_request(p);
      release_req();
    end
  endtask

  // Drain all responses, check the status and its clear, then report
  task automatic finish_test(input int n, input string name, input logic expect_clean);
    ready_random = 1'b0;
    @(posedge clk);
    req <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_status(status, expect_clean ? mon_status_t'('0) : model_status, "status");
    @(posedge clk);
    status_clear <= 1'b1;
    @(posedge clk);
    status_clear <= 1'b0;
    @(negedge clk);
    check_status(status, '0, "status after clear");
    $display("test %0d %s: %0d checks, %0d errors", n, name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin : run
    obi_req_t p;
    obi_req_t alt;
    req          = 1'b0;
    req_payload  = '0;
    rready       = 1'b0;
    status_clear = 1'b0;
    @(negedge clk);
    while (reset) @(negedge clk);
    check_bit(gnt, 1'b0, "gnt after reset");
    check_bit(rvalid, 1'b0, "rvalid after reset");
    check_status(status, '0, "status after reset");

    // Every word gets random contents, so later reads never see X
    for (int i = 0; i < MEM_WORDS; i++) begin
      p      = legal_req(1'b1, 1'b1);
      p.addr = i * 4;
      send_request(p);
    end
    for (int i = 0; i < N_RUN; i++) begin
      p = legal_req(1'b1, 1'b1);
      check_words.push_back(int'(p.addr >> 2));
      send_request(p);
      release_req();
    end
    read_back();
    finish_test(1, "full word writes and reads", 1'b1);

    // Byte and halfword lanes merge into the existing word
    for (int i = 0; i < N_RUN; i++) begin
      p = legal_req(1'b1, 1'b0);
      check_words.push_back(int'(p.addr >> 2));
      send_request(p);
      release_req();
    end
    read_back();
    finish_test(2, "partial writes", 1'b1);

    // Refused requests must leave the aliased words untouched
    for (int i = 0; i < N_RUN; i++) begin
      p = illegal_req(i % 4);
      check_words.push_back(int'((p.addr >> 2) % MEM_WORDS));
      send_request(p);
      release_req();
    end
    read_back();
    check_bit(status.be_zero, 1'b1, "be_zero flag");
    check_bit(status.be_noncontig, 1'b1, "be_noncontig flag");
    check_bit(status.be_misaligned, 1'b1, "be_misaligned flag");
    finish_test(3, "illegal requests", 1'b0);

    // Mostly back to back requests against a slow requester
    ready_random = 1'b1;
    for (int i = 0; i < 2 * N_RUN; i++) begin
      send_request(legal_req(take_bits(1), take_bits(1)));
      if (take_bits(2) == 0) begin
        release_req();
      end
    end
    finish_test(4, "rready back-pressure", 1'b1);

    // Alternate payload changes and dropped requests before the grant
    for (int i = 0; i < N_BREACH; i++) begin
      p         = legal_req(take_bits(1), 1'b0);
      alt       = p;
      alt.wdata = ~p.wdata;
      if (i % 2 == 0) begin
        send_with_change(p, alt);
      end else begin
        send_with_drop(p);
      end
      release_req();
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_bit(status.addr_unstable, 1'b1, "addr_unstable flag");
    check_bit(status.req_dropped, 1'b1, "req_dropped flag");
    finish_test(5, "handshake breaches", 1'b0);

    $display("all tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Each request gets its wait states plus a generous response margin
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped granting or answering",
             WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== test/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source
 * 100 ns clock with a synchronous reset held for the first three edges
 */

`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Reset falls on the rising edge that ends the last reset cycle
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule
